// File: sim.f
+incdir+test
common/mm_pkg.sv
source/word_ram.sv
source/ctrl_regs.sv
host/host_sequencer.sv
engine/mm_engine.sv
source/mm_system.sv
test/tb_mm_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mm_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mm_system \
  -Mdir obj_dir -o tb_mm_system
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mm_system > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** FAILED ***" "$log"; then
  echo "simulation reported failure, see $log"
  exit 1
fi
echo "simulation passed"
exit 0

// File: test/tb_mm_checks.svh
`ifndef TB_MM_CHECKS_SVH
`define TB_MM_CHECKS_SVH

// model operands, feature (i,k) unsigned and weight (k,j) signed
logic [7:0]        feat_mod [max_dim][max_dim];
logic signed [7:0] wgt_mod  [max_dim][max_dim];
acc_t              exp_q [$];  // expected results in row-major order

int value_errs = 0;
int count_errs = 0;
int proto_errs = 0;

// sum over k of feature times weight, pad lanes never enter
task automatic build_model(input dim_t m, input dim_t n, input dim_t p);
  int sum;
  exp_q.delete();
  for (int i = 0; i < int'(m); i++) begin
    for (int j = 0; j < int'(p); j++) begin
      sum = 0;
      for (int k = 0; k < int'(n); k++) begin
        sum = sum + int'(feat_mod[i][k]) * int'(wgt_mod[k][j]);
      end
      exp_q.push_back(acc_t'(sum));
    end
  end
endtask

task automatic check_result(input acc_t got, input acc_t exp_v);
  if (got !== exp_v) begin
    value_errs++;
    $display("Error at %0t: res_data = %0d, expected %0d", $time, got, exp_v);
  end
endtask

task automatic check_count(input dim_t got, input dim_t exp_v);
  if (got !== exp_v) begin
    count_errs++;
    $display("Error at %0t: res_valid count = %0d, expected %0d", $time, got, exp_v);
  end
endtask

`endif

// File: test/tb_mm_system.sv
`default_nettype none

module tb_mm_system;
  import mm_pkg::*;

  localparam int     max_dim      = 10;
  localparam int     num_runs     = 12;
  localparam longint limit_cycles =
    longint'(num_runs) * longint'(max_dim ** 3 + 3 * max_dim ** 2 + 100);

  logic  arm_clk;
  logic  rst;
  logic  start;
  dim_t  dim_m;
  dim_t  dim_n;
  dim_t  dim_p;
  logic  fm_valid;
  word_t fm_word;
  logic  wm_valid;
  word_t wm_word;
  logic  res_valid;
  acc_t  res_data;
  logic  done;

  int   runs_started = 0;
  int   runs_done    = 0;
  int   res_count    = 0;
  logic prev_valid   = 1'b0;
  dim_t cur_m;
  dim_t cur_p;

  `include "tb_mm_checks.svh"

  mm_system #(
    .max_dim (max_dim)
  ) u_mm_system (
    .arm_clk   (arm_clk),
    .rst       (rst),
    .start     (start),
    .dim_m     (dim_m),
    .dim_n     (dim_n),
    .dim_p     (dim_p),
    .fm_valid  (fm_valid),
    .fm_word   (fm_word),
    .wm_valid  (wm_valid),
    .wm_word   (wm_word),
    .res_valid (res_valid),
    .res_data  (res_data),
    .done      (done)
  );

  initial begin
    arm_clk = 1'b0;
    forever #10 arm_clk = ~arm_clk;
  end

  task automatic show_counts();
    $display("errors: %0d value, %0d count, %0d protocol", value_errs, count_errs, proto_errs);
  endtask

  // mode 1 gives every feature 255 and every weight -128
  task automatic fill_operands(input dim_t m, input dim_t n, input dim_t p, input int mode);
    for (int k = 0; k < int'(n); k++) begin
      for (int i = 0; i < int'(m); i++) begin
        feat_mod[i][k] = (mode == 1) ? 8'd255 : 8'($urandom_range(255, 0));
      end
      for (int j = 0; j < int'(p); j++) begin
        wgt_mod[k][j] = (mode == 1) ? -8'sd128 : 8'($urandom_range(255, 0));
      end
    end
  endtask

  task automatic send_word(input logic is_wm, input word_t w);
    if ($urandom_range(2, 0) == 0) begin
      @(posedge arm_clk);  // random gap
      fm_valid <= 1'b0;
      wm_valid <= 1'b0;
    end
    @(posedge arm_clk);
    fm_valid <= !is_wm;
    wm_valid <= is_wm;
    fm_word  <= w;
    wm_word  <= w;
  endtask

  // packed column k of features or row k of weights with nonzero junk in pad lanes
  task automatic stream_matrix(input logic is_wm, input dim_t len, input dim_t n);
    word_t w;
    int    idx;
    for (int k = 0; k < int'(n); k++) begin
      for (int q = 0; q < (int'(len) + lanes - 1) / lanes; q++) begin
        for (int l = 0; l < lanes; l++) begin
          idx = q * lanes + l;
          if (idx >= int'(len)) begin
            w[8*l +: 8] = 8'($urandom_range(255, 1));
          end else if (is_wm) begin
            w[8*l +: 8] = wgt_mod[k][idx];
          end else begin
            w[8*l +: 8] = feat_mod[idx][k];
          end
        end
        send_word(is_wm, w);
      end
    end
  endtask

  // sampled on the falling edge away from the driving edge
  always @(negedge arm_clk) begin
    if (runs_started == runs_done) begin
      if (res_valid || done) begin
        proto_errs++;
        $display("output strobe while no run was active at %0t", $time);
      end
    end else begin
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("more results than expected at %0t", $time);
        end else begin
          check_result(res_data, exp_q.pop_front());
        end
        res_count++;
      end
      if (done) begin
        check_count(dim_t'(res_count), dim_t'(cur_m * cur_p));
        if (!prev_valid || res_valid) begin
          proto_errs++;
          $display("done did not follow the last result by one cycle at %0t", $time);
        end
        res_count = 0;
        runs_done++;
      end
    end
    prev_valid = res_valid;
  end

  initial begin
    repeat (limit_cycles) @(posedge arm_clk);
    $display("timeout after %0d cycles, %0d of %0d runs done", limit_cycles, runs_done,
             num_runs);
    show_counts();
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    dim_t m;
    dim_t n;
    dim_t p;
    int   mode;
    void'($urandom(67));
    rst      = 1'b1;
    start    = 1'b0;
    dim_m    = '0;
    dim_n    = '0;
    dim_p    = '0;
    fm_valid = 1'b0;
    fm_word  = '0;
    wm_valid = 1'b0;
    wm_word  = '0;
    repeat (4) @(posedge arm_clk);
    rst <= 1'b0;
    repeat (10) @(posedge arm_clk);  // idle outputs watched by the monitor

    for (int r = 0; r < num_runs; r++) begin
      mode = (r == 2) ? 1 : 0;
      if (r == 0) begin
        m = 1;
        n = 1;
        p = 1;
      end else if (r <= 2) begin
        m = dim_t'(max_dim);
        n = dim_t'(max_dim);
        p = dim_t'(max_dim);
      end else begin
        m = dim_t'($urandom_range(max_dim, 1));
        n = dim_t'($urandom_range(max_dim, 1));
        p = dim_t'($urandom_range(max_dim, 1));
      end
      fill_operands(m, n, p, mode);
      build_model(m, n, p);
      cur_m = m;
      cur_p = p;
      runs_started++;

      @(posedge arm_clk);
      start <= 1'b1;
      dim_m <= m;
      dim_n <= n;
      dim_p <= p;
      @(posedge arm_clk);
      start <= 1'b0;
      stream_matrix(1'b0, m, n);
      stream_matrix(1'b1, p, n);
      @(posedge arm_clk);
      fm_valid <= 1'b0;
      wm_valid <= 1'b0;
      if (r % 2 == 1) begin
        start <= 1'b1;  // sequencer is busy now, so this one must be dropped
        dim_m <= dim_t'($urandom_range(max_dim, 1));
        dim_p <= dim_t'($urandom_range(max_dim, 1));
        @(posedge arm_clk);
        start <= 1'b0;
      end
      wait (runs_done == r + 1);
    end

    repeat (5) @(posedge arm_clk);
    show_counts();
    if (value_errs + count_errs + proto_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/mm_system.sv
`default_nettype none

module mm_system #(
  parameter int max_dim = 10
) (
  input  logic         arm_clk,
  input  logic         rst,
  input  logic         start,
  input  mm_pkg::dim_t dim_m,
  input  mm_pkg::dim_t dim_n,
  input  mm_pkg::dim_t dim_p,
  input  logic         fm_valid,
  input  mm_pkg::word_t fm_word,
  input  logic         wm_valid,
  input  mm_pkg::word_t wm_word,
  output logic         res_valid,
  output mm_pkg::acc_t res_data,
  output logic         done
);
  import mm_pkg::*;

  // packed inputs need ceil(max_dim/lanes) words per row, results one word each
  localparam int in_depth  = max_dim * ((max_dim + lanes - 1) / lanes);
  localparam int out_depth = max_dim * max_dim;
  localparam int in_aw     = $clog2(in_depth);
  localparam int out_aw    = $clog2(out_depth);

  logic              fm_we;
  logic [in_aw-1:0]  fm_waddr;
  word_t             fm_wdata;
  logic [in_aw-1:0]  fm_raddr;
  word_t             fm_rdata;
  logic              wm_we;
  logic [in_aw-1:0]  wm_waddr;
  word_t             wm_wdata;
  logic [in_aw-1:0]  wm_raddr;
  word_t             wm_rdata;
  logic              out_we;
  logic [out_aw-1:0] out_waddr;
  acc_t              out_wdata;
  logic [out_aw-1:0] out_raddr;
  word_t             out_rdata;
  logic              ctrl_we;
  logic [1:0]        ctrl_addr;
  ctrl_word_u        ctrl_wdata;
  ctrl_word_u        com1;
  ctrl_word_u        com2;
  ctrl_word_u        flag;
  logic              flag_we;
  word_t             flag_code;

  host_sequencer #(
    .max_dim (max_dim)
  ) u_host_sequencer (
    .arm_clk    (arm_clk),
    .rst        (rst),
    .start      (start),
    .dim_m      (dim_m),
    .dim_n      (dim_n),
    .dim_p      (dim_p),
    .fm_valid   (fm_valid),
    .fm_word    (fm_word),
    .wm_valid   (wm_valid),
    .wm_word    (wm_word),
    .fm_we      (fm_we),
    .fm_waddr   (fm_waddr),
    .fm_wdata   (fm_wdata),
    .wm_we      (wm_we),
    .wm_waddr   (wm_waddr),
    .wm_wdata   (wm_wdata),
    .ctrl_we    (ctrl_we),
    .ctrl_addr  (ctrl_addr),
    .ctrl_wdata (ctrl_wdata),
    .flag       (flag),
    .out_raddr  (out_raddr),
    .out_rdata  (out_rdata),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .done       (done)
  );

  word_ram #(
    .depth (in_depth)
  ) u_fm_ram (
    .arm_clk (arm_clk),
    .we      (fm_we),
    .waddr   (fm_waddr),
    .wdata   (fm_wdata),
    .raddr   (fm_raddr),
    .rdata   (fm_rdata)
  );

  word_ram #(
    .depth (in_depth)
  ) u_wm_ram (
    .arm_clk (arm_clk),
    .we      (wm_we),
    .waddr   (wm_waddr),
    .wdata   (wm_wdata),
    .raddr   (wm_raddr),
    .rdata   (wm_rdata)
  );

  word_ram #(
    .depth (out_depth)
  ) u_out_ram (
    .arm_clk (arm_clk),
    .we      (out_we),
    .waddr   (out_waddr),
    .wdata   (word_t'(out_wdata)),
    .raddr   (out_raddr),
    .rdata   (out_rdata)
  );

  ctrl_regs u_ctrl_regs (
    .arm_clk       (arm_clk),
    .rst           (rst),
    .host_we       (ctrl_we),
    .host_addr     (ctrl_addr),
    .host_wdata    (ctrl_wdata),
    .eng_flag_we   (flag_we),
    .eng_flag_code (flag_code),
    .com1          (com1),
    .com2          (com2),
    .flag          (flag)
  );

  mm_engine #(
    .max_dim (max_dim)
  ) u_mm_engine (
    .arm_clk   (arm_clk),
    .rst       (rst),
    .com1      (com1),
    .com2      (com2),
    .flag      (flag),
    .fm_raddr  (fm_raddr),
    .fm_rdata  (fm_rdata),
    .wm_raddr  (wm_raddr),
    .wm_rdata  (wm_rdata),
    .out_we    (out_we),
    .out_waddr (out_waddr),
    .out_wdata (out_wdata),
    .flag_we   (flag_we),
    .flag_code (flag_code)
  );

endmodule

`default_nettype wire

// File: engine/mm_engine.sv
`default_nettype none

module mm_engine #(
  parameter  int max_dim = 10,
  localparam int in_aw   = $clog2(max_dim * ((max_dim + mm_pkg::lanes - 1) / mm_pkg::lanes)),
  localparam int out_aw  = $clog2(max_dim * max_dim)
) (
  input  logic               arm_clk,
  input  logic               rst,
  input  mm_pkg::ctrl_word_u com1,
  input  mm_pkg::ctrl_word_u com2,
  input  mm_pkg::ctrl_word_u flag,
  output logic [in_aw-1:0]   fm_raddr,
  input  mm_pkg::word_t      fm_rdata,
  output logic [in_aw-1:0]   wm_raddr,
  input  mm_pkg::word_t      wm_rdata,
  output logic               out_we,
  output logic [out_aw-1:0]  out_waddr,
  output mm_pkg::acc_t       out_wdata,
  output logic               flag_we,
  output mm_pkg::word_t      flag_code
);
  import mm_pkg::*;

  localparam int lw = $clog2(lanes);

  localparam logic [1:0] e_idle  = 2'd0;
  localparam logic [1:0] e_walk  = 2'd1;
  localparam logic [1:0] e_drain = 2'd2;

  logic [1:0] state;
  dim_t       m;
  dim_t       n;
  dim_t       p;
  dim_t       m_words;
  dim_t       p_words;
  dim_t       i;
  dim_t       j;
  dim_t       k;
  dim_t       fm_idx;
  dim_t       wm_idx;
  dim_t       out_idx;

  // stage 1, memory data back
  logic              s1_v;
  logic              s1_first;
  logic              s1_last;
  logic [lw-1:0]     s1_il;
  logic [lw-1:0]     s1_jl;
  logic [out_aw-1:0] s1_oaddr;
  // stage 2, registered product
  logic              s2_v;
  logic              s2_first;
  logic              s2_last;
  logic [out_aw-1:0] s2_oaddr;
  acc_t              s2_prod;
  acc_t              acc;

  logic [7:0]         feat;
  logic signed [7:0]  wgt;
  logic signed [16:0] prod;

  assign m = com1.dims[0];
  assign p = com1.dims[1];
  assign n = com2.dims[0];

  assign m_words = dim_t'((m + lanes - 1) / lanes);
  assign p_words = dim_t'((p + lanes - 1) / lanes);

  // column k of features, row k of weights
  assign fm_idx  = dim_t'(k * m_words + i / lanes);
  assign wm_idx  = dim_t'(k * p_words + j / lanes);
  assign out_idx = dim_t'(i * p + j);  // row-major

  assign fm_raddr = fm_idx[in_aw-1:0];
  assign wm_raddr = wm_idx[in_aw-1:0];

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state     <= e_idle;
      i         <= '0;
      j         <= '0;
      k         <= '0;
      flag_we   <= 1'b0;
      flag_code <= '0;
    end else begin
      flag_we <= 1'b0;
      case (state)
        e_idle: begin
          if (flag.code == flag_start) begin
            flag_we   <= 1'b1;
            flag_code <= flag_busy;
            i         <= '0;
            j         <= '0;
            k         <= '0;
            state     <= e_walk;
          end
        end
        e_walk: begin
          // k innermost, one read pair per cycle
          if (k == n - 1'b1) begin
            k <= '0;
            if (j == p - 1'b1) begin
              j <= '0;
              if (i == m - 1'b1) begin
                i     <= '0;
                state <= e_drain;
              end else begin
                i <= i + 1'b1;
              end
            end else begin
              j <= j + 1'b1;
            end
          end else begin
            k <= k + 1'b1;
          end
        end
        e_drain: begin
          // pipe empty and the last result going out now
          if (out_we && !s1_v && !s2_v) begin
            flag_we   <= 1'b1;
            flag_code <= flag_finish;
            state     <= e_idle;
          end
        end
        default: state <= e_idle;
      endcase
    end
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      s1_v   <= 1'b0;
      s2_v   <= 1'b0;
      out_we <= 1'b0;
    end else begin
      s1_v   <= (state == e_walk);
      s2_v   <= s1_v;
      out_we <= s2_v && s2_last;
    end
  end

  // lane picks, feature unsigned and weight signed
  assign feat = fm_rdata[8*s1_il +: 8];
  assign wgt  = wm_rdata[8*s1_jl +: 8];
  assign prod = $signed({1'b0, feat}) * wgt;

  always_ff @(posedge arm_clk) begin
    s1_first  <= (k == '0);
    s1_last   <= (k == n - 1'b1);
    s1_il     <= i[lw-1:0];
    s1_jl     <= j[lw-1:0];
    s1_oaddr  <= out_idx[out_aw-1:0];
    s2_first  <= s1_first;
    s2_last   <= s1_last;
    s2_oaddr  <= s1_oaddr;
    s2_prod   <= acc_t'(prod);  // sign extended
    out_waddr <= s2_oaddr;
    if (s2_v) begin
      acc <= s2_first ? s2_prod : acc + s2_prod;
    end
  end

  assign out_wdata = acc;  // held for the write cycle

  // results land only between the busy and finish flag updates
  assert property (@(posedge arm_clk) disable iff (rst) out_we |-> flag.code == flag_busy)
    else $error("result write outside a busy run");

endmodule

`default_nettype wire

// File: host/host_sequencer.sv
`default_nettype none

module host_sequencer #(
  parameter  int max_dim = 10,
  localparam int in_aw   = $clog2(max_dim * ((max_dim + mm_pkg::lanes - 1) / mm_pkg::lanes)),
  localparam int out_aw  = $clog2(max_dim * max_dim)
) (
  input  logic               arm_clk,
  input  logic               rst,
  input  logic               start,
  input  mm_pkg::dim_t       dim_m,
  input  mm_pkg::dim_t       dim_n,
  input  mm_pkg::dim_t       dim_p,
  input  logic               fm_valid,
  input  mm_pkg::word_t      fm_word,
  input  logic               wm_valid,
  input  mm_pkg::word_t      wm_word,
  output logic               fm_we,
  output logic [in_aw-1:0]   fm_waddr,
  output mm_pkg::word_t      fm_wdata,
  output logic               wm_we,
  output logic [in_aw-1:0]   wm_waddr,
  output mm_pkg::word_t      wm_wdata,
  output logic               ctrl_we,
  output logic [1:0]         ctrl_addr,
  output mm_pkg::ctrl_word_u ctrl_wdata,
  input  mm_pkg::ctrl_word_u flag,
  output logic [out_aw-1:0]  out_raddr,
  input  mm_pkg::word_t      out_rdata,
  output logic               res_valid,
  output mm_pkg::acc_t       res_data,
  output logic               done
);
  import mm_pkg::*;

  localparam logic [2:0] idle       = 3'd0;
  localparam logic [2:0] load_fm    = 3'd1;
  localparam logic [2:0] load_wm    = 3'd2;
  localparam logic [2:0] write_cmd  = 3'd3;
  localparam logic [2:0] write_flag = 3'd4;
  localparam logic [2:0] wait_flag  = 3'd5;
  localparam logic [2:0] read_out   = 3'd6;
  localparam logic [2:0] finish     = 3'd7;

  logic [2:0] state;
  dim_t       cnt;  // shared by every phase, back to zero at each phase end
  dim_t       m_q;
  dim_t       n_q;
  dim_t       p_q;
  dim_t       fm_last;
  dim_t       wm_last;
  dim_t       mp_last;

  // dimensions and phase lengths, taken with start
  always_ff @(posedge arm_clk) begin
    if (state == idle && start) begin
      m_q     <= dim_m;
      n_q     <= dim_n;
      p_q     <= dim_p;
      fm_last <= dim_t'(dim_n * ((dim_m + lanes - 1) / lanes) - 1);
      wm_last <= dim_t'(dim_n * ((dim_p + lanes - 1) / lanes) - 1);
      mp_last <= dim_t'(dim_m * dim_p - 1);
    end
  end

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      state     <= idle;
      cnt       <= '0;
      res_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      res_valid <= (state == read_out);  // data lags its address by one cycle
      done      <= (state == finish);
      case (state)
        idle: begin
          if (start) begin
            state <= load_fm;
          end
        end
        load_fm: begin
          if (fm_valid) begin
            if (cnt == fm_last) begin
              cnt   <= '0;
              state <= load_wm;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        load_wm: begin
          if (wm_valid) begin
            if (cnt == wm_last) begin
              cnt   <= '0;
              state <= write_cmd;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        write_cmd: begin
          if (cnt == dim_t'(1)) begin
            cnt   <= '0;
            state <= write_flag;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        write_flag: state <= wait_flag;
        wait_flag: begin
          if (flag.code == flag_finish) begin
            state <= read_out;
          end
        end
        read_out: begin
          if (cnt == mp_last) begin
            cnt   <= '0;
            state <= finish;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        finish:  state <= idle;  // last result is on the output now
        default: state <= idle;
      endcase
    end
  end

  assign fm_we    = (state == load_fm) && fm_valid;
  assign fm_waddr = cnt[in_aw-1:0];
  assign fm_wdata = fm_word;
  assign wm_we    = (state == load_wm) && wm_valid;
  assign wm_waddr = cnt[in_aw-1:0];
  assign wm_wdata = wm_word;

  assign out_raddr = cnt[out_aw-1:0];
  assign res_data  = acc_t'(out_rdata);

  // two command words, then the start flag
  always_comb begin
    ctrl_we    = 1'b0;
    ctrl_addr  = addr_flag;
    ctrl_wdata = '0;
    case (state)
      write_cmd: begin
        ctrl_we = 1'b1;
        if (cnt == '0) begin
          ctrl_addr          = addr_com1;
          ctrl_wdata.dims[1] = p_q;
          ctrl_wdata.dims[0] = m_q;
        end else begin
          ctrl_addr          = addr_com2;
          ctrl_wdata.dims[0] = n_q;
        end
      end
      write_flag: begin
        ctrl_we         = 1'b1;
        ctrl_wdata.code = flag_start;
      end
      default: ;
    endcase
  end

  assert property (@(posedge arm_clk) disable iff (rst)
    (state == idle && start) |=>
      (m_q != '0 && n_q != '0 && p_q != '0 &&
       m_q <= max_dim && n_q <= max_dim && p_q <= max_dim))
    else $error("start with a dimension outside 1..max_dim");

endmodule

`default_nettype wire

// File: source/ctrl_regs.sv
`default_nettype none

module ctrl_regs (
  input  logic               arm_clk,
  input  logic               rst,
  input  logic               host_we,
  input  logic [1:0]         host_addr,
  input  mm_pkg::ctrl_word_u host_wdata,
  input  logic               eng_flag_we,
  input  mm_pkg::word_t      eng_flag_code,
  output mm_pkg::ctrl_word_u com1,
  output mm_pkg::ctrl_word_u com2,
  output mm_pkg::ctrl_word_u flag
);
  import mm_pkg::*;

  always_ff @(posedge arm_clk or posedge rst) begin
    if (rst) begin
      com1 <= '0;
      com2 <= '0;
      flag <= '0;
    end else if (host_we) begin
      case (host_addr)
        addr_flag: flag <= host_wdata;
        addr_com1: com1 <= host_wdata;
        addr_com2: com2 <= host_wdata;
        default: ;  // word 3 unmapped
      endcase
    end else if (eng_flag_we) begin
      flag.code <= eng_flag_code;  // engine only ever touches the flag
    end
  end

  // host and engine take turns on the flag word
  assert property (@(posedge arm_clk) disable iff (rst) !(host_we && eng_flag_we))
    else $error("host and engine wrote the control block in the same cycle");

endmodule

`default_nettype wire

// File: source/word_ram.sv
`default_nettype none

module word_ram #(
  parameter  int depth = 16,
  localparam int aw    = $clog2(depth)
) (
  input  logic          arm_clk,
  input  logic          we,
  input  logic [aw-1:0] waddr,
  input  mm_pkg::word_t wdata,
  input  logic [aw-1:0] raddr,
  output mm_pkg::word_t rdata
);
  import mm_pkg::*;

  word_t mem [depth];

  // registered read, old data on a same-cycle collision
  always_ff @(posedge arm_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: common/mm_pkg.sv
`default_nettype none

package mm_pkg;

  localparam int lanes = 4;  // 8-bit lanes per memory word, lane 0 in the low byte

  typedef logic [15:0]        dim_t;
  typedef logic [31:0]        word_t;
  typedef logic signed [31:0] acc_t;

  // command words hold a dimension pair and the flag word holds one code
  typedef union packed {
    dim_t [1:0] dims;  // [1] upper half, [0] lower half
    word_t      code;
  } ctrl_word_u;

  // flag word handshake between host and engine
  localparam word_t flag_start  = 32'h5a5a_0001;
  localparam word_t flag_busy   = 32'h5a5a_0002;
  localparam word_t flag_finish = 32'h5a5a_0003;

  // control block word map
  localparam logic [1:0] addr_flag = 2'd0;
  localparam logic [1:0] addr_com1 = 2'd1;  // {P, M}
  localparam logic [1:0] addr_com2 = 2'd2;  // {0, N}

endpackage

`default_nettype wire
